/* sim.f */
source/cache_pkg.sv
source/cache_ctrl_pkg.sv
source/cache_write_buffer.sv
source/cache_front_stage.sv
source/cache_lookup_stage.sv
source/cache_control.sv
source/cache_top.sv
verification/cache_assertions.sv
verification/cache_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build cache_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module cache_tb -f sim.f -Mdir obj_dir
	./obj_dir/Vcache_tb | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/cache_tb.sv */
module cache_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import cache_pkg::*;
   import cache_ctrl_pkg::*;

   localparam int    NUM_RANDOM     = 536;     // 64 directed requests follow
   localparam int    TIMEOUT_CYCLES = 600 * 40;
   localparam addr_t WIN_BASE       = 12'h100;
   localparam int    WIN_SIZE       = 48;      // Three tags per line index

   logic  clk_i = 1'b0;
   logic  reset;
   logic  req_valid, req_ready, req_ctrl, req_we;
   addr_t req_addr;
   data_t req_wdata;
   logic  rsp_valid, rsp_ready;
   data_t rsp_rdata;
   logic  mem_valid, mem_ready, mem_we;
   addr_t mem_addr;
   data_t mem_wdata, mem_rdata;

   integer seed = 32'hde18;
   int     cycles = 0;
   int     mem_delay = 0;
   data_t  mem_array [1 << ADDR_W];
   data_t  shadow    [1 << ADDR_W];   // Memory as the CPU sees it
   logic   model_valid [LINES];
   tag_t   model_tag   [LINES];
   cnt_t   rh_cnt, rm_cnt, wh_cnt, wm_cnt;

   cache_top i_dut (
      .clk_i(clk_i), .reset(reset),
      .req_valid(req_valid), .req_ready(req_ready), .req_ctrl(req_ctrl),
      .req_addr(req_addr), .req_we(req_we), .req_wdata(req_wdata),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
      .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_we(mem_we),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
   );

   always #4 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   // Stop at the first handshake assertion failure
   always @(negedge clk_i) begin
      if (i_dut.i_assertions.fail_count != 0) begin
         $display("A handshake assertion failed in the DUT");
         abort_run();
      end
   end

   // Memory responder with 0 to 3 wait cycles
   always @(negedge clk_i) begin
      if (mem_ready) begin
         mem_ready = 1'b0;  // Transfer happened at the last rising edge
         mem_delay = $unsigned($random(seed)) % 4;
      end else if (mem_valid) begin
         if (mem_delay == 0) begin
            mem_ready = 1'b1;
            if (mem_we)
               mem_array[mem_addr] = mem_wdata;
            else
               mem_rdata = mem_array[mem_addr];
         end else begin
            mem_delay = mem_delay - 1;
         end
      end
   end

   task automatic abort_run();
      $display("TEST FAIL");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic check_data(string name, data_t actual, data_t expected);
      if (actual !== expected) begin
         $display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_count(string name, cnt_t actual, cnt_t expected);
      if (actual !== expected) begin
         $display("Error at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
         abort_run();
      end
   endtask

   function automatic data_t fill_word(addr_t a);
      return {a, 8'ha5, ~a};
   endfunction

   // Read misses allocate and write misses leave the line alone
   function automatic void model_access(addr_t a, logic we);
      index_t idx;
      logic   hit;
      idx = a[INDEX_W-1:0];
      hit = model_valid[idx] && (model_tag[idx] == a[ADDR_W-1:INDEX_W]);
      if (we && hit) begin
         wh_cnt++;
      end else if (we) begin
         wm_cnt++;
      end else if (hit) begin
         rh_cnt++;
      end else begin
         rm_cnt++;
         model_valid[idx] = 1'b1;
         model_tag[idx]   = a[ADDR_W-1:INDEX_W];
      end
   endfunction

   function automatic cnt_t model_register(ctrl_addr_t a);
      case (a)
         CTRL_HIT_CNT:    return rh_cnt + wh_cnt;
         CTRL_MISS_CNT:   return rm_cnt + wm_cnt;
         CTRL_READ_HIT:   return rh_cnt;
         CTRL_READ_MISS:  return rm_cnt;
         CTRL_WRITE_HIT:  return wh_cnt;
         CTRL_WRITE_MISS: return wm_cnt;
         default:         return '0;
      endcase
   endfunction

   function automatic void clear_counters();
      rh_cnt = '0;
      rm_cnt = '0;
      wh_cnt = '0;
      wm_cnt = '0;
   endfunction

   task automatic send_request(logic ctrl, addr_t addr, logic we, data_t wdata,
                               output data_t rdata);
      int hold;
      @(negedge clk_i);
      req_valid = 1'b1;
      req_ctrl  = ctrl;
      req_addr  = addr;
      req_we    = we;
      req_wdata = wdata;
      while (!req_ready)
         @(negedge clk_i);
      @(negedge clk_i);  // Accepted at the rising edge in between
      req_valid = 1'b0;
      while (!rsp_valid)
         @(negedge clk_i);
      hold = $unsigned($random(seed)) % 3;
      repeat (hold) @(negedge clk_i);
      rdata     = rsp_rdata;
      rsp_ready = 1'b1;
      @(negedge clk_i);
      rsp_ready = 1'b0;
   endtask

   task automatic cache_read(addr_t addr);
      data_t rdata;
      model_access(addr, 1'b0);
      send_request(1'b0, addr, 1'b0, '0, rdata);
      check_data($sformatf("rsp_rdata (read of %h)", addr), rdata, shadow[addr]);
   endtask

   task automatic cache_write(addr_t addr, data_t wdata);
      data_t rdata;
      model_access(addr, 1'b1);
      shadow[addr] = wdata;
      send_request(1'b0, addr, 1'b1, wdata, rdata);
      check_data($sformatf("rsp_rdata (write of %h)", addr), rdata, '0);
   endtask

   task automatic ctrl_read(ctrl_addr_t reg_addr, output data_t rdata);
      cnt_t expected;
      expected = model_register(reg_addr);
      send_request(1'b1, addr_t'(reg_addr), 1'b0, '0, rdata);
      if (reg_addr == CTRL_CLEAR)
         check_data("rsp_rdata (version)", rdata, data_t'(CACHE_VERSION));
      else if (reg_addr != CTRL_STATUS)
         check_count($sformatf("rsp_rdata (counter register %0d)", reg_addr),
                     cnt_t'(rdata), expected);
   endtask

   task automatic ctrl_write(ctrl_addr_t reg_addr, data_t wdata);
      data_t rdata;
      send_request(1'b1, addr_t'(reg_addr), 1'b1, wdata, rdata);
      check_data("rsp_rdata (control write)", rdata, '0);
      if (reg_addr == CTRL_CLEAR)
         clear_counters();
      if (reg_addr == CTRL_STATUS) begin
         for (int i = 0; i < LINES; i++)
            model_valid[i] = 1'b0;
      end
   endtask

   // Memory port quiet for 8 cycles means the buffer is empty
   task automatic wait_mem_idle();
      int quiet;
      quiet = 0;
      while (quiet < 8) begin
         @(negedge clk_i);
         if (mem_valid)
            quiet = 0;
         else
            quiet++;
      end
   endtask

   initial begin
      data_t rdata;
      int    pick;
      addr_t addr;
      reset     = 1'b1;
      req_valid = 1'b0;
      req_ctrl  = 1'b0;
      req_addr  = '0;
      req_we    = 1'b0;
      req_wdata = '0;
      rsp_ready = 1'b0;
      mem_ready = 1'b0;
      mem_rdata = '0;
      for (int a = 0; a < (1 << ADDR_W); a++) begin
         mem_array[a] = fill_word(addr_t'(a));
         shadow[a]    = fill_word(addr_t'(a));
      end
      for (int i = 0; i < LINES; i++)
         model_valid[i] = 1'b0;
      clear_counters();
      repeat (10) @(negedge clk_i);
      reset = 1'b0;

      for (int n = 0; n < NUM_RANDOM; n++) begin
         pick = $unsigned($random(seed)) % 100;
         addr = WIN_BASE + addr_t'($unsigned($random(seed)) % WIN_SIZE);
         if (pick < 70) begin
            if ($random(seed) & 1)
               cache_write(addr, $random(seed));
            else
               cache_read(addr);
         end else if (pick < 90) begin
            ctrl_read(ctrl_addr_t'($unsigned($random(seed)) % 8), rdata);
         end else begin
            ctrl_write(ctrl_addr_t'($unsigned($random(seed)) % 8), $random(seed));
         end
      end

      // Counters restart from zero
      ctrl_write(CTRL_CLEAR, '1);
      for (int r = 0; r < 6; r++)
         ctrl_read(ctrl_addr_t'(r), rdata);

      // Every line misses after the invalidate and reads back from memory
      ctrl_write(CTRL_STATUS, '0);
      for (int a = 0; a < WIN_SIZE; a++)
         cache_read(WIN_BASE + addr_t'(a));
      for (int r = 0; r < 6; r++)
         ctrl_read(ctrl_addr_t'(r), rdata);

      wait_mem_idle();
      for (int a = 0; a < WIN_SIZE; a++) begin
         addr = WIN_BASE + addr_t'(a);
         check_data($sformatf("mem_array[%h]", addr), mem_array[addr], shadow[addr]);
      end
      ctrl_read(CTRL_CLEAR, rdata);
      ctrl_read(CTRL_STATUS, rdata);
      check_data("rsp_rdata (status)", rdata, 32'h1);  // Empty set, full clear

      if (i_dut.i_assertions.fail_count == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         $display("%0d assertion failures during the run", i_dut.i_assertions.fail_count);
         abort_run();
      end
   end

endmodule

/* verification/cache_assertions.sv */
module cache_assertions (
   input logic              clk_i,
   input logic              reset,
   input logic              req_ready,
   input logic              rsp_valid,
   input logic              rsp_ready,
   input cache_pkg::data_t  rsp_rdata,
   input logic              mem_valid,
   input logic              mem_ready,
   input logic              mem_we,
   input cache_pkg::addr_t  mem_addr,
   input cache_pkg::data_t  mem_wdata
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;

   rsp_hold: assert property (@(posedge clk_i) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
      else begin
         fail_count++;
         $error("Response dropped or changed before rsp_ready");
      end

   // Request fields held until mem_ready
   mem_hold: assert property (@(posedge clk_i) disable iff (reset)
      mem_valid && !mem_ready |=>
         mem_valid && $stable(mem_we) && $stable(mem_addr) && $stable(mem_wdata))
      else begin
         fail_count++;
         $error("Memory request dropped or changed before mem_ready");
      end

   busy_while_rsp: assert property (@(posedge clk_i) disable iff (reset)
      rsp_valid |-> !req_ready)
      else begin
         fail_count++;
         $error("req_ready high while a response is pending");
      end

   reset_state: assert property (@(posedge clk_i)
      $fell(reset) |-> !rsp_valid && !mem_valid)
      else begin
         fail_count++;
         $error("rsp_valid or mem_valid high after reset");
      end

endmodule

bind cache_top cache_assertions i_assertions (
   .clk_i(clk_i), .reset(reset),
   .req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
   .rsp_rdata(rsp_rdata),
   .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_we(mem_we),
   .mem_addr(mem_addr), .mem_wdata(mem_wdata)
);

/* source/cache_top.sv */
module cache_top (
   input  logic              clk_i,
   input  logic              reset,
   input  logic              req_valid,
   output logic              req_ready,
   input  logic              req_ctrl,
   input  cache_pkg::addr_t  req_addr,
   input  logic              req_we,
   input  cache_pkg::data_t  req_wdata,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   output cache_pkg::data_t  rsp_rdata,
   output logic              mem_valid,
   input  logic              mem_ready,
   output logic              mem_we,
   output cache_pkg::addr_t  mem_addr,
   output cache_pkg::data_t  mem_wdata,
   input  cache_pkg::data_t  mem_rdata
);
   import cache_pkg::*;
   import cache_ctrl_pkg::*;

   logic       lk_valid, lk_we, lk_done;
   addr_t      lk_addr;
   data_t      lk_wdata, lk_rdata;
   logic       ctrl_valid, ctrl_we, ctrl_ready;
   ctrl_addr_t ctrl_addr;
   data_t      ctrl_wdata, ctrl_rdata;
   logic       read_hit, read_miss, write_hit, write_miss, invalidate;
   logic       wb_push, wb_full, wb_empty, wb_valid, wb_pop;
   addr_t      wb_push_addr, wb_addr;
   data_t      wb_push_data, wb_data;

   cache_front_stage i_front (
      .clk_i(clk_i), .reset(reset),
      .req_valid(req_valid), .req_ready(req_ready), .req_ctrl(req_ctrl),
      .req_addr(req_addr), .req_we(req_we), .req_wdata(req_wdata),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
      .lk_valid(lk_valid), .lk_addr(lk_addr), .lk_we(lk_we), .lk_wdata(lk_wdata),
      .lk_done(lk_done), .lk_rdata(lk_rdata),
      .ctrl_valid(ctrl_valid), .ctrl_addr(ctrl_addr), .ctrl_we(ctrl_we),
      .ctrl_wdata(ctrl_wdata), .ctrl_ready(ctrl_ready), .ctrl_rdata(ctrl_rdata)
   );

   cache_lookup_stage i_lookup (
      .clk_i(clk_i), .reset(reset),
      .lk_valid(lk_valid), .lk_addr(lk_addr), .lk_we(lk_we), .lk_wdata(lk_wdata),
      .lk_done(lk_done), .lk_rdata(lk_rdata),
      .read_hit(read_hit), .read_miss(read_miss),
      .write_hit(write_hit), .write_miss(write_miss), .invalidate(invalidate),
      .wb_push(wb_push), .wb_push_addr(wb_push_addr), .wb_push_data(wb_push_data),
      .wb_full(wb_full), .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
      .wb_pop(wb_pop),
      .mem_valid(mem_valid), .mem_we(mem_we), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata)
   );

   cache_write_buffer #(.DEPTH(WB_DEPTH_DEFAULT)) i_wbuf (
      .clk_i(clk_i), .reset(reset),
      .wb_push(wb_push), .wb_push_addr(wb_push_addr), .wb_push_data(wb_push_data),
      .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data), .wb_pop(wb_pop),
      .wb_empty(wb_empty), .wb_full(wb_full)
   );

   cache_control i_control (
      .clk_i(clk_i), .reset(reset),
      .ctrl_valid(ctrl_valid), .ctrl_addr(ctrl_addr), .ctrl_we(ctrl_we),
      .ctrl_wdata(ctrl_wdata), .ctrl_ready(ctrl_ready), .ctrl_rdata(ctrl_rdata),
      .read_hit(read_hit), .read_miss(read_miss),
      .write_hit(write_hit), .write_miss(write_miss),
      .wb_empty(wb_empty), .wb_full(wb_full), .invalidate(invalidate)
   );

endmodule

/* source/cache_control.sv */
module cache_control (
   input  logic                        clk_i,
   input  logic                        reset,
   input  logic                        ctrl_valid,
   input  cache_ctrl_pkg::ctrl_addr_t  ctrl_addr,
   input  logic                        ctrl_we,
   input  cache_pkg::data_t            ctrl_wdata,
   output logic                        ctrl_ready,
   output cache_pkg::data_t            ctrl_rdata,
   input  logic                        read_hit,
   input  logic                        read_miss,
   input  logic                        write_hit,
   input  logic                        write_miss,
   input  logic                        wb_empty,
   input  logic                        wb_full,
   output logic                        invalidate
);
   import cache_pkg::*;
   import cache_ctrl_pkg::*;

   cnt_t read_hit_cnt, read_miss_cnt, write_hit_cnt, write_miss_cnt;
   cnt_t hit_cnt, miss_cnt;
   logic clear_q;
   logic ctrl_wr;

   assign hit_cnt  = read_hit_cnt + write_hit_cnt;
   assign miss_cnt = read_miss_cnt + write_miss_cnt;
   assign ctrl_wr  = ctrl_valid && ctrl_we;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         read_hit_cnt   <= '0;
         read_miss_cnt  <= '0;
         write_hit_cnt  <= '0;
         write_miss_cnt <= '0;
         clear_q        <= 1'b0;
         ctrl_ready     <= 1'b0;
         invalidate     <= 1'b0;
      end else begin
         ctrl_ready <= ctrl_valid;  // Answer one cycle after the request
         clear_q    <= ctrl_wr && (ctrl_addr == CTRL_CLEAR);
         invalidate <= ctrl_wr && (ctrl_addr == CTRL_STATUS);
         if (clear_q) begin
            read_hit_cnt   <= '0;
            read_miss_cnt  <= '0;
            write_hit_cnt  <= '0;
            write_miss_cnt <= '0;
         end else begin
            if (read_hit)   read_hit_cnt   <= read_hit_cnt + 1'b1;
            if (read_miss)  read_miss_cnt  <= read_miss_cnt + 1'b1;
            if (write_hit)  write_hit_cnt  <= write_hit_cnt + 1'b1;
            if (write_miss) write_miss_cnt <= write_miss_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      ctrl_rdata <= '0;
      if (ctrl_valid && !ctrl_we) begin
         case (ctrl_addr)
            CTRL_HIT_CNT:    ctrl_rdata <= hit_cnt;
            CTRL_MISS_CNT:   ctrl_rdata <= miss_cnt;
            CTRL_READ_HIT:   ctrl_rdata <= read_hit_cnt;
            CTRL_READ_MISS:  ctrl_rdata <= read_miss_cnt;
            CTRL_WRITE_HIT:  ctrl_rdata <= write_hit_cnt;
            CTRL_WRITE_MISS: ctrl_rdata <= write_miss_cnt;
            CTRL_CLEAR:      ctrl_rdata <= data_t'(CACHE_VERSION);
            CTRL_STATUS:     ctrl_rdata <= data_t'({wb_full, wb_empty});
            default:         ctrl_rdata <= '0;
         endcase
      end
   end

endmodule

/* source/cache_lookup_stage.sv */
module cache_lookup_stage (
   input  logic              clk_i,
   input  logic              reset,
   input  logic              lk_valid,
   input  cache_pkg::addr_t  lk_addr,
   input  logic              lk_we,
   input  cache_pkg::data_t  lk_wdata,
   output logic              lk_done,
   output cache_pkg::data_t  lk_rdata,
   output logic              read_hit,
   output logic              read_miss,
   output logic              write_hit,
   output logic              write_miss,
   input  logic              invalidate,
   output logic              wb_push,
   output cache_pkg::addr_t  wb_push_addr,
   output cache_pkg::data_t  wb_push_data,
   input  logic              wb_full,
   input  logic              wb_valid,
   input  cache_pkg::addr_t  wb_addr,
   input  cache_pkg::data_t  wb_data,
   output logic              wb_pop,
   output logic              mem_valid,
   output logic              mem_we,
   output cache_pkg::addr_t  mem_addr,
   output cache_pkg::data_t  mem_wdata,
   input  logic              mem_ready,
   input  cache_pkg::data_t  mem_rdata
);
   import cache_pkg::*;

   lookup_state_t    state;
   logic [LINES-1:0] valid_q;
   tag_t             tag_q  [LINES];
   data_t            data_q [LINES];
   addr_t            req_addr_q;
   data_t            req_wdata_q;
   logic             wr_pend;  // Write stalled on a full buffer

   logic  rd_req, lk_hit, wr_hit;
   logic  mem_xfer, issue_wr, issue_rd;
   addr_t wr_addr;
   data_t wr_data;

   assign rd_req = (state == IDLE) && lk_valid && !lk_we;
   assign lk_hit = valid_q[addr_index(lk_addr)] &&
                   (tag_q[addr_index(lk_addr)] == addr_tag(lk_addr));

   assign wr_addr = wr_pend ? req_addr_q : lk_addr;
   assign wr_data = wr_pend ? req_wdata_q : lk_wdata;
   assign wr_hit  = valid_q[addr_index(wr_addr)] &&
                    (tag_q[addr_index(wr_addr)] == addr_tag(wr_addr));

   assign wb_push      = (state == IDLE) && (wr_pend || (lk_valid && lk_we)) && !wb_full;
   assign wb_push_addr = wr_addr;
   assign wb_push_data = wr_data;

   assign mem_xfer = mem_valid && mem_ready;
   assign wb_pop   = mem_xfer && mem_we;
   // Drain in IDLE and DRAIN; the fill read only once the buffer is empty
   assign issue_wr = !mem_valid && wb_valid && (state == IDLE || state == DRAIN);
   assign issue_rd = !mem_valid && !wb_valid && (state == DRAIN);

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state      <= IDLE;
         valid_q    <= '0;
         wr_pend    <= 1'b0;
         lk_done    <= 1'b0;
         read_hit   <= 1'b0;
         read_miss  <= 1'b0;
         write_hit  <= 1'b0;
         write_miss <= 1'b0;
         mem_valid  <= 1'b0;
      end else begin
         lk_done    <= 1'b0;
         read_hit   <= 1'b0;
         read_miss  <= 1'b0;
         write_hit  <= 1'b0;
         write_miss <= 1'b0;
         if (mem_xfer)
            mem_valid <= 1'b0;
         else if (issue_wr || issue_rd)
            mem_valid <= 1'b1;

         case (state)
            IDLE: begin
               if (rd_req) begin
                  if (lk_hit) begin
                     lk_done  <= 1'b1;
                     read_hit <= 1'b1;
                  end else begin
                     read_miss <= 1'b1;
                     state     <= DRAIN;
                  end
               end
               if (wb_push) begin
                  lk_done    <= 1'b1;
                  write_hit  <= wr_hit;
                  write_miss <= !wr_hit;
                  wr_pend    <= 1'b0;
               end else if (lk_valid && lk_we) begin
                  wr_pend <= 1'b1;
               end
            end
            DRAIN:
               if (issue_rd) state <= FILL;
            FILL:
               if (mem_xfer) begin
                  valid_q[addr_index(req_addr_q)] <= 1'b1;
                  state                           <= RESPOND;
               end
            RESPOND: begin
               lk_done <= 1'b1;
               state   <= IDLE;
            end
            default: state <= IDLE;
         endcase

         if (invalidate) valid_q <= '0;  // Only arrives while idle
      end
   end

   always_ff @(posedge clk_i) begin
      if (lk_valid) begin
         req_addr_q  <= lk_addr;
         req_wdata_q <= lk_wdata;
      end
      if (rd_req)
         lk_rdata <= data_q[addr_index(lk_addr)];
      else if (wb_push)
         lk_rdata <= '0;  // Writes answer zero
      else if (state == RESPOND)
         lk_rdata <= data_q[addr_index(req_addr_q)];

      if (wb_push && wr_hit)
         data_q[addr_index(wr_addr)] <= wr_data;
      if (state == FILL && mem_xfer) begin
         data_q[addr_index(req_addr_q)] <= mem_rdata;
         tag_q[addr_index(req_addr_q)]  <= addr_tag(req_addr_q);
      end

      if (issue_wr) begin
         mem_we    <= 1'b1;
         mem_addr  <= wb_addr;
         mem_wdata <= wb_data;
      end else if (issue_rd) begin
         mem_we   <= 1'b0;
         mem_addr <= req_addr_q;
      end
   end

endmodule

/* source/cache_front_stage.sv */
module cache_front_stage (
   input  logic                        clk_i,
   input  logic                        reset,
   input  logic                        req_valid,
   output logic                        req_ready,
   input  logic                        req_ctrl,
   input  cache_pkg::addr_t            req_addr,
   input  logic                        req_we,
   input  cache_pkg::data_t            req_wdata,
   output logic                        rsp_valid,
   input  logic                        rsp_ready,
   output cache_pkg::data_t            rsp_rdata,
   output logic                        lk_valid,
   output cache_pkg::addr_t            lk_addr,
   output logic                        lk_we,
   output cache_pkg::data_t            lk_wdata,
   input  logic                        lk_done,
   input  cache_pkg::data_t            lk_rdata,
   output logic                        ctrl_valid,
   output cache_ctrl_pkg::ctrl_addr_t  ctrl_addr,
   output logic                        ctrl_we,
   output cache_pkg::data_t            ctrl_wdata,
   input  logic                        ctrl_ready,
   input  cache_pkg::data_t            ctrl_rdata
);
   import cache_pkg::*;

   logic  in_flight;
   logic  accept;
   addr_t addr_q;
   logic  we_q;
   data_t wdata_q;

   assign req_ready = !in_flight;  // One request at a time
   assign accept    = req_valid && req_ready;

   assign lk_addr    = addr_q;
   assign lk_we      = we_q;
   assign lk_wdata   = wdata_q;
   assign ctrl_addr  = addr_q[$bits(ctrl_addr)-1:0];
   assign ctrl_we    = we_q;
   assign ctrl_wdata = wdata_q;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         in_flight  <= 1'b0;
         rsp_valid  <= 1'b0;
         lk_valid   <= 1'b0;
         ctrl_valid <= 1'b0;
      end else begin
         lk_valid   <= accept && !req_ctrl;
         ctrl_valid <= accept && req_ctrl;
         if (accept)
            in_flight <= 1'b1;
         else if (rsp_valid && rsp_ready)
            in_flight <= 1'b0;
         if (lk_done || ctrl_ready)
            rsp_valid <= 1'b1;
         else if (rsp_ready)
            rsp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_q  <= req_addr;
         we_q    <= req_we;
         wdata_q <= req_wdata;
      end
      if (lk_done || ctrl_ready)
         rsp_rdata <= lk_done ? lk_rdata : ctrl_rdata;
   end

endmodule

/* source/cache_write_buffer.sv */
module cache_write_buffer #(
   parameter int DEPTH = cache_pkg::WB_DEPTH_DEFAULT
) (
   input  logic              clk_i,
   input  logic              reset,
   input  logic              wb_push,
   input  cache_pkg::addr_t  wb_push_addr,
   input  cache_pkg::data_t  wb_push_data,
   output logic              wb_valid,
   output cache_pkg::addr_t  wb_addr,
   output cache_pkg::data_t  wb_data,
   input  logic              wb_pop,
   output logic              wb_empty,
   output logic              wb_full
);
   import cache_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);

   addr_t            addr_mem [DEPTH];
   data_t            data_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;  // Wraps by itself, DEPTH is a power of two
   logic [PTR_W:0]   count;

   assign wb_empty = (count == '0);
   assign wb_full  = (count == (PTR_W+1)'(DEPTH));
   assign wb_valid = !wb_empty;
   assign wb_addr  = addr_mem[rd_ptr];
   assign wb_data  = data_mem[rd_ptr];

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wb_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (wb_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({wb_push, wb_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (wb_push) begin
         addr_mem[wr_ptr] <= wb_push_addr;
         data_mem[wr_ptr] <= wb_push_data;
      end
   end

endmodule

/* source/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

   typedef logic [2:0]  ctrl_addr_t;
   typedef logic [31:0] cnt_t;

   // Register map
   localparam ctrl_addr_t CTRL_HIT_CNT    = 3'd0;  // Read plus write hits
   localparam ctrl_addr_t CTRL_MISS_CNT   = 3'd1;
   localparam ctrl_addr_t CTRL_READ_HIT   = 3'd2;
   localparam ctrl_addr_t CTRL_READ_MISS  = 3'd3;
   localparam ctrl_addr_t CTRL_WRITE_HIT  = 3'd4;
   localparam ctrl_addr_t CTRL_WRITE_MISS = 3'd5;
   localparam ctrl_addr_t CTRL_CLEAR      = 3'd6;  // Write clears, read gives version
   localparam ctrl_addr_t CTRL_STATUS     = 3'd7;  // Write invalidates

   localparam logic [7:0] CACHE_VERSION = 8'h21;

endpackage

/* source/cache_pkg.sv */
package cache_pkg;

   // Cache geometry
   localparam int ADDR_W  = 12;
   localparam int DATA_W  = 32;
   localparam int INDEX_W = 4;
   localparam int TAG_W   = ADDR_W - INDEX_W;

   localparam int LINES            = 1 << INDEX_W;
   localparam int WB_DEPTH_DEFAULT = 4;

   typedef logic [ADDR_W-1:0]  addr_t;   // Word address
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [INDEX_W-1:0] index_t;  // Low address bits
   typedef logic [TAG_W-1:0]   tag_t;    // High address bits

   typedef enum logic [1:0] {
      IDLE,
      DRAIN,    // Empty the write buffer before a fill
      FILL,     // Memory read of the missing word
      RESPOND
   } lookup_state_t;

   function automatic index_t addr_index(addr_t addr);
      return addr[INDEX_W-1:0];
   endfunction

   function automatic tag_t addr_tag(addr_t addr);
      return addr[ADDR_W-1:INDEX_W];
   endfunction

endpackage
